//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := lcd_controller_tb
FILELIST  := lcd_controller.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/lcd_controller_checker.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_controller_checker #(
  parameter int active_lines = 144
) (
  input wire                  clock,
  input wire                  reset,
  input wire                  hsync,
  input wire                  vblank_req,
  input wire                  lcdc_req,
  input wire                  vblank_ack,
  input wire                  lcdc_ack,
  input lcd_pkg::lcd_mode_e   mode,
  input lcd_pkg::line_count_t line_count
);

  // Requests come out of reset clear
  reqs_clear_after_reset: assert property (
    @(posedge clock) reset |=> (!vblank_req && !lcdc_req)
  ) else $error("interrupt request high in the cycle after reset");

  // Mode lags the counters by one clock
  hsync_gives_hblank: assert property (
    @(posedge clock) disable iff (reset)
    (hsync && (int'(line_count) < active_lines)) |=> (mode == lcd_pkg::hblank_mode)
  ) else $error("mode not hblank one clock after hsync in an active line");

  no_transfer_in_vblank: assert property (
    @(posedge clock) disable iff (reset)
    !((mode == lcd_pkg::transfer_mode) && (int'(line_count) >= active_lines))
  ) else $error("transfer mode seen on a vblank line");

  ////////////////////////////////////////
  // Requests drop only on an ack
  ////////////////////////////////////////

  vblank_falls_on_ack: assert property (
    @(posedge clock) disable iff (reset) $fell(vblank_req) |-> $past(vblank_ack)
  ) else $error("vblank_req fell without vblank_ack");

  lcdc_falls_on_ack: assert property (
    @(posedge clock) disable iff (reset) $fell(lcdc_req) |-> $past(lcdc_ack)
  ) else $error("lcdc_req fell without lcdc_ack");

endmodule

// Internal mode and line_count come from the top level scope
bind lcd_controller lcd_controller_checker #(
  .active_lines (active_lines)
) u_checker (
  .clock      (clock),
  .reset      (reset),
  .hsync      (hsync),
  .vblank_req (vblank_req),
  .lcdc_req   (lcdc_req),
  .vblank_ack (vblank_ack),
  .lcdc_ack   (lcdc_ack),
  .mode       (mode),
  .line_count (line_count)
);

`default_nettype wire

//--- dv/lcd_controller_monitor.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_controller_monitor #(
  parameter int dot_divide      = 8,
  parameter int dots_per_line   = 456,
  parameter int lines_per_frame = 154,
  parameter int active_lines    = 144,
  parameter int oam_dots        = 80,
  parameter int transfer_dots   = 172,
  parameter int active_dots     = 160
) (
  input  wire                clock,
  input  wire                reset,
  input  wire                cs,
  input  wire                rd_n,
  input  wire                wr_n,
  input  lcd_pkg::bus_addr_t addr,
  input  lcd_pkg::reg_byte_t wdata,
  input  lcd_pkg::reg_byte_t rdata,
  input  wire                vblank_ack,
  input  wire                vblank_req,
  input  wire                lcdc_ack,
  input  wire                lcdc_req,
  input  wire                hsync,
  input  wire                vsync,
  output int                 check_count,
  output int                 error_count
);

  // Reference state, advanced once per clock
  lcd_pkg::reg_byte_t  m_lcdc;
  lcd_pkg::stat_bits_t m_stat;
  lcd_pkg::reg_byte_t  m_lyc;
  lcd_pkg::reg_byte_t  m_rdata;
  lcd_pkg::lcd_mode_e  m_mode;
  int                  m_div;
  int                  m_dot;
  int                  m_line;
  logic                m_vreq;
  logic                m_lreq;
  logic                model_valid;
  string               read_name;

  initial begin
    check_count = 0;
    error_count = 0;
    model_valid = 1'b0;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch %s expected %0h actual %0h at %0t", name, expected, actual, $time);
    end
  endtask

  ////////////////////////////////////////
  // Compare then advance the model
  ////////////////////////////////////////

  // Everything here sees pre-edge values
  always @(posedge clock) begin : model_step
    lcd_pkg::lcd_mode_e next_mode;
    logic enter_v;
    logic enter_o;
    logic enter_h;
    logic vset;
    logic lset;
    logic dot_en;
    if (model_valid) begin
      check_value(read_name, 32'(m_rdata), 32'(rdata));
      check_value("vblank_req", 32'(m_vreq), 32'(vblank_req));
      check_value("lcdc_req", 32'(m_lreq), 32'(lcdc_req));
      check_value("hsync", 32'(m_dot > oam_dots + transfer_dots + active_dots), 32'(hsync));
      check_value("vsync", 32'(m_line > active_lines), 32'(vsync));
    end
    if (reset) begin
      m_lcdc      = '0;
      m_stat      = '0;
      m_lyc       = '0;
      m_rdata     = '0;
      m_mode      = lcd_pkg::hblank_mode;
      m_div       = 0;
      m_dot       = 0;
      m_line      = 0;
      m_vreq      = 1'b0;
      m_lreq      = 1'b0;
      read_name   = "rdata after reset";
      model_valid = 1'b1;
    end else begin
      // Mode from the counters as they stood before this edge
      if (!m_lcdc[7]) begin
        next_mode = lcd_pkg::hblank_mode;
      end else if (m_line >= active_lines) begin
        next_mode = lcd_pkg::vblank_mode;
      end else if (m_dot < oam_dots) begin
        next_mode = lcd_pkg::oam_search_mode;
      end else if (m_dot < oam_dots + transfer_dots) begin
        next_mode = lcd_pkg::transfer_mode;
      end else begin
        next_mode = lcd_pkg::hblank_mode;
      end
      enter_v = (next_mode == lcd_pkg::vblank_mode) && (m_mode != lcd_pkg::vblank_mode);
      enter_o = (next_mode == lcd_pkg::oam_search_mode) && (m_mode != lcd_pkg::oam_search_mode);
      enter_h = (next_mode == lcd_pkg::hblank_mode) && (m_mode != lcd_pkg::hblank_mode);
      // STAT select bits 3 to 6 sit in m_stat[0] to m_stat[3]
      vset = m_lcdc[7] && enter_v;
      lset = m_lcdc[7] && ((enter_h && m_stat[0]) || (enter_v && m_stat[1]) ||
                           (enter_o && m_stat[2]) ||
                           (m_dot == 0 && m_line == int'(m_lyc) && m_stat[3]));
      // Set beats a same-edge ack
      if (vset) begin
        m_vreq = 1'b1;
      end else if (vblank_ack) begin
        m_vreq = 1'b0;
      end
      if (lset) begin
        m_lreq = 1'b1;
      end else if (lcdc_ack) begin
        m_lreq = 1'b0;
      end
      if (cs && !rd_n) begin
        case (addr)
          lcd_pkg::lcdc_addr: begin
            m_rdata   = m_lcdc;
            read_name = "lcdc read-back";
          end
          lcd_pkg::stat_addr: begin
            m_rdata   = {m_stat, (m_line == int'(m_lyc)), m_mode};
            read_name = "stat read";
          end
          lcd_pkg::ly_addr: begin
            m_rdata   = lcd_pkg::reg_byte_t'(m_line);
            read_name = "ly read";
          end
          lcd_pkg::lyc_addr: begin
            m_rdata   = m_lyc;
            read_name = "lyc read-back";
          end
          default: begin
            m_rdata   = 8'hFF;
            read_name = "unmapped read";
          end
        endcase
      end
      // Dot enable and raster counters
      dot_en = (m_div == dot_divide - 1);
      m_div  = dot_en ? 0 : m_div + 1;
      if (dot_en) begin
        if (!m_lcdc[7]) begin
          m_dot  = 0;
          m_line = 0;
        end else if (m_dot == dots_per_line - 1) begin
          m_dot  = 0;
          m_line = (m_line == lines_per_frame - 1) ? 0 : m_line + 1;
        end else begin
          m_dot = m_dot + 1;
        end
      end
      m_mode = next_mode;
      // Writes last so the steps above use old register values
      if (cs && rd_n && !wr_n) begin
        if (addr == lcd_pkg::lcdc_addr) begin
          m_lcdc = wdata;
        end else if (addr == lcd_pkg::stat_addr) begin
          m_stat = wdata[7:3];
        end else if (addr == lcd_pkg::lyc_addr) begin
          m_lyc = wdata;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/lcd_controller_tb.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_controller_tb;

  // Short raster so several frames fit in one run
  localparam int dot_divide      = 2;
  localparam int dots_per_line   = 40;
  localparam int lines_per_frame = 12;
  localparam int active_lines    = 8;
  localparam int oam_dots        = 8;
  localparam int transfer_dots   = 14;
  localparam int active_dots     = 10;

  // Run length in frames and its cycle bound
  localparam int target_frames  = 6;
  localparam int timeout_cycles = 50000;

  logic                 clock;
  logic                 reset;
  logic                 cs;
  logic                 rd_n;
  logic                 wr_n;
  lcd_pkg::bus_addr_t   addr;
  lcd_pkg::reg_byte_t   wdata;
  lcd_pkg::reg_byte_t   rdata;
  logic                 vblank_ack;
  logic                 vblank_req;
  logic                 lcdc_ack;
  logic                 lcdc_req;
  logic                 hsync;
  logic                 vsync;

  // Random source and run bookkeeping
  logic [31:0] lfsr_state;
  int          check_count;
  int          error_count;
  int          frames_seen;
  int          cycle_count;
  logic        prev_vsync;
  logic        timed_out;
  logic        run_complete;

  // Port names match the signals above
  lcd_controller #(
    .dot_divide      (dot_divide),
    .dots_per_line   (dots_per_line),
    .lines_per_frame (lines_per_frame),
    .active_lines    (active_lines),
    .oam_dots        (oam_dots),
    .transfer_dots   (transfer_dots),
    .active_dots     (active_dots)
  ) u_dut (.*);

  lcd_controller_monitor #(
    .dot_divide      (dot_divide),
    .dots_per_line   (dots_per_line),
    .lines_per_frame (lines_per_frame),
    .active_lines    (active_lines),
    .oam_dots        (oam_dots),
    .transfer_dots   (transfer_dots),
    .active_dots     (active_dots)
  ) u_monitor (.*);

  ////////////////////////////////////////
  // Random bits
  ////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] galois_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = galois_step(lfsr_state);
    end
  endtask

  // STAT and LY come up more often than the rest
  function automatic lcd_pkg::bus_addr_t read_address(input logic [2:0] pick);
    case (pick)
      3'd0:    return lcd_pkg::lcdc_addr;
      3'd2:    return lcd_pkg::ly_addr;
      3'd3:    return lcd_pkg::lyc_addr;
      3'd5:    return lcd_pkg::ly_addr;
      3'd6:    return 16'hFF42;
      default: return lcd_pkg::stat_addr;
    endcase
  endfunction

  ////////////////////////////////////////
  // Bus and ack stimulus
  ////////////////////////////////////////

  task automatic drive_random_cycle();
    logic [31:0] op;
    logic [31:0] pick;
    logic [31:0] data;
    logic [31:0] rare;
    draw_bits(4, op);
    draw_bits(3, pick);
    draw_bits(8, data);
    cs         <= 1'b0;
    rd_n       <= 1'b1;
    wr_n       <= 1'b1;
    vblank_ack <= 1'b0;
    lcdc_ack   <= 1'b0;
    if (op < 8) begin
      // Idle with strobes wiggling under cs low
      rd_n <= pick[0];
      wr_n <= pick[1];
    end else if (op < 11) begin
      // Read with wr_n random since read wins
      cs   <= 1'b1;
      rd_n <= 1'b0;
      wr_n <= data[0];
      addr <= read_address(pick[2:0]);
    end else if (op < 14) begin
      cs   <= 1'b1;
      wr_n <= 1'b0;
      case (pick[1:0])
        2'd0: begin
          // Display off roughly once in 64 LCDC writes
          draw_bits(6, rare);
          addr  <= lcd_pkg::lcdc_addr;
          wdata <= {|rare[5:0], data[6:0]};
        end
        2'd1: begin
          addr  <= lcd_pkg::stat_addr;
          wdata <= data[7:0];
        end
        2'd2: begin
          // Small LYC so it meets real lines
          addr  <= lcd_pkg::lyc_addr;
          wdata <= {4'h0, data[3:0]};
        end
        default: begin
          addr  <= lcd_pkg::ly_addr;
          wdata <= data[7:0];
        end
      endcase
    end else begin
      vblank_ack <= pick[0];
      lcdc_ack   <= pick[1];
    end
  endtask

  ////////////////////////////////////////
  // Clock and main sequence
  ////////////////////////////////////////

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    lfsr_state   = 32'hc958_9d08;
    reset        = 1'b1;
    cs           = 1'b0;
    rd_n         = 1'b1;
    wr_n         = 1'b1;
    addr         = '0;
    wdata        = '0;
    vblank_ack   = 1'b0;
    lcdc_ack     = 1'b0;
    frames_seen  = 0;
    cycle_count  = 0;
    prev_vsync   = 1'b0;
    timed_out    = 1'b0;
    run_complete = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    // Frames are counted on vsync rising
    while (frames_seen < target_frames && !timed_out) begin
      @(posedge clock);
      if (vsync && !prev_vsync) begin
        frames_seen++;
      end
      prev_vsync = vsync;
      drive_random_cycle();
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
        timed_out = 1'b1;
      end
    end
    if (timed_out) begin
      $display("timeout after %0d cycles with only %0d of %0d frames seen",
               cycle_count, frames_seen, target_frames);
    end
    // Quiet bus so the last read is compared
    @(posedge clock);
    cs         <= 1'b0;
    vblank_ack <= 1'b0;
    lcdc_ack   <= 1'b0;
    repeat (3) @(posedge clock);
    // Counts are settled away from the rising edge
    @(negedge clock);
    $display("checks %0d errors %0d frames %0d", check_count, error_count, frames_seen);
    run_complete = 1'b1;
    if (error_count == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Run stopped early by a failing assertion
  final begin
    if (!run_complete) begin
      $display("checks %0d errors %0d frames %0d", check_count, error_count, frames_seen);
      $display("FAIL: see errors above");
    end
  end

endmodule

`default_nettype wire

//--- lcd_controller.f
verilog/lcd_pkg.sv
verilog/lcd_host_regs.sv
verilog/lcd_video_timing.sv
verilog/lcd_mode_irq.sv
verilog/lcd_controller.sv
dv/lcd_controller_monitor.sv
dv/lcd_controller_checker.sv
dv/lcd_controller_tb.sv

//--- verilog/lcd_controller.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_controller #(
  parameter int dot_divide      = 8,
  parameter int dots_per_line   = 456,
  parameter int lines_per_frame = 154,
  parameter int active_lines    = 144,
  parameter int oam_dots        = 80,
  parameter int transfer_dots   = 172,
  parameter int active_dots     = 160
) (
  input  wire                 clock,
  input  wire                 reset,
  // Host bus
  input  wire                 cs,
  input  wire                 rd_n,
  input  wire                 wr_n,
  input  lcd_pkg::bus_addr_t  addr,
  input  lcd_pkg::reg_byte_t  wdata,
  output lcd_pkg::reg_byte_t  rdata,
  // Interrupts
  input  wire                 vblank_ack,
  output logic                vblank_req,
  input  wire                 lcdc_ack,
  output logic                lcdc_req,
  // LCD sync
  output logic                hsync,
  output logic                vsync
);

  // Control from the register block
  logic                 lcd_enable;
  logic [3:0]           stat_select;
  lcd_pkg::line_count_t lyc;

  // Raster position
  lcd_pkg::dot_count_t  dot_count;
  lcd_pkg::line_count_t line_count;

  // Status back to STAT
  lcd_pkg::lcd_mode_e   mode;
  logic                 coincidence;

  lcd_host_regs u_host_regs (
    .clock       (clock),
    .reset       (reset),
    .cs          (cs),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .addr        (addr),
    .wdata       (wdata),
    .rdata       (rdata),
    .line_count  (line_count),
    .mode        (mode),
    .coincidence (coincidence),
    .lcd_enable  (lcd_enable),
    .stat_select (stat_select),
    .lyc         (lyc)
  );

  lcd_video_timing #(
    .dot_divide      (dot_divide),
    .dots_per_line   (dots_per_line),
    .lines_per_frame (lines_per_frame),
    .active_lines    (active_lines),
    .oam_dots        (oam_dots),
    .transfer_dots   (transfer_dots),
    .active_dots     (active_dots)
  ) u_video_timing (
    .clock      (clock),
    .reset      (reset),
    .lcd_enable (lcd_enable),
    .dot_count  (dot_count),
    .line_count (line_count),
    .hsync      (hsync),
    .vsync      (vsync)
  );

  lcd_mode_irq #(
    .active_lines  (active_lines),
    .oam_dots      (oam_dots),
    .transfer_dots (transfer_dots)
  ) u_mode_irq (
    .clock       (clock),
    .reset       (reset),
    .lcd_enable  (lcd_enable),
    .dot_count   (dot_count),
    .line_count  (line_count),
    .lyc         (lyc),
    .stat_select (stat_select),
    .vblank_ack  (vblank_ack),
    .lcdc_ack    (lcdc_ack),
    .mode        (mode),
    .coincidence (coincidence),
    .vblank_req  (vblank_req),
    .lcdc_req    (lcdc_req)
  );

endmodule

`default_nettype wire

//--- verilog/lcd_host_regs.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_host_regs (
  input  wire                 clock,
  input  wire                 reset,
  // Host bus strobes
  input  wire                 cs,
  input  wire                 rd_n,
  input  wire                 wr_n,
  input  lcd_pkg::bus_addr_t  addr,
  input  lcd_pkg::reg_byte_t  wdata,
  output lcd_pkg::reg_byte_t  rdata,
  // Status from the timing side
  input  lcd_pkg::line_count_t line_count,
  input  lcd_pkg::lcd_mode_e  mode,
  input  wire                 coincidence,
  // Control to the timing side
  output logic                lcd_enable,
  output logic [3:0]          stat_select,
  output lcd_pkg::line_count_t lyc
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Full LCDC byte kept for read-back
  lcd_pkg::reg_byte_t  lcdc;

  // STAT bits 7 to 3
  lcd_pkg::stat_bits_t stat_bits;

  // Assembled STAT read value
  lcd_pkg::reg_byte_t  stat_value;

  // Bus cycle qualifiers
  logic host_read;
  logic host_write;

  // Read wins when both strobes are low
  assign host_read  = cs && !rd_n;
  assign host_write = cs && rd_n && !wr_n;

  // Stored select bits, then the live flag and mode
  assign stat_value = {stat_bits, coincidence, mode};

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      lcdc      <= '0;
      stat_bits <= '0;
      lyc       <= '0;
    end else if (host_write) begin
      case (addr)
        lcd_pkg::lcdc_addr: lcdc <= wdata;
        lcd_pkg::stat_addr: stat_bits <= wdata[7:3];
        lcd_pkg::lyc_addr:  lyc <= wdata;
        // LY is read only
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Registered read mux
  ////////////////////////////////////////

  // rdata holds until the next read
  always_ff @(posedge clock) begin
    if (reset) begin
      rdata <= '0;
    end else if (host_read) begin
      case (addr)
        lcd_pkg::lcdc_addr: rdata <= lcdc;
        lcd_pkg::stat_addr: rdata <= stat_value;
        lcd_pkg::ly_addr:   rdata <= line_count;
        lcd_pkg::lyc_addr:  rdata <= lyc;
        default:            rdata <= lcd_pkg::unmapped_data;
      endcase
    end
  end

  // Display on/off
  assign lcd_enable = lcdc[7];

  // Interrupt selects sit in STAT bits 6 to 3
  assign stat_select = stat_bits[3:0];

endmodule

`default_nettype wire

//--- verilog/lcd_mode_irq.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_mode_irq #(
  parameter int active_lines  = 144,
  parameter int oam_dots      = 80,
  parameter int transfer_dots = 172
) (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   lcd_enable,
  input  lcd_pkg::dot_count_t   dot_count,
  input  lcd_pkg::line_count_t  line_count,
  input  lcd_pkg::line_count_t  lyc,
  input  wire [3:0]             stat_select,
  input  wire                   vblank_ack,
  input  wire                   lcdc_ack,
  output lcd_pkg::lcd_mode_e    mode,
  output logic                  coincidence,
  output logic                  vblank_req,
  output logic                  lcdc_req
);

  // Mode boundaries in counter units
  localparam lcd_pkg::line_count_t first_vblank_line = lcd_pkg::line_count_t'(active_lines);
  localparam lcd_pkg::dot_count_t  transfer_start    = lcd_pkg::dot_count_t'(oam_dots);
  localparam lcd_pkg::dot_count_t  hblank_start      =
    lcd_pkg::dot_count_t'(oam_dots + transfer_dots);

  lcd_pkg::lcd_mode_e mode_next;

  // Mode entry and LYC match events
  logic enter_vblank;
  logic enter_oam;
  logic enter_hblank;
  logic lyc_hit;
  logic vblank_set;
  logic lcdc_set;

  ////////////////////////////////////////
  // Mode decode
  ////////////////////////////////////////

  always_comb begin
    if (!lcd_enable) begin
      mode_next = lcd_pkg::hblank_mode;
    end else if (line_count >= first_vblank_line) begin
      mode_next = lcd_pkg::vblank_mode;
    end else if (dot_count < transfer_start) begin
      mode_next = lcd_pkg::oam_search_mode;
    end else if (dot_count < hblank_start) begin
      mode_next = lcd_pkg::transfer_mode;
    end else begin
      mode_next = lcd_pkg::hblank_mode;
    end
  end

  // LY against LYC
  assign coincidence = (line_count == lyc);

  // Entry means new mode differs from the stored one
  assign enter_vblank = (mode_next == lcd_pkg::vblank_mode) && (mode != lcd_pkg::vblank_mode);
  assign enter_oam    = (mode_next == lcd_pkg::oam_search_mode) &&
                        (mode != lcd_pkg::oam_search_mode);
  assign enter_hblank = (mode_next == lcd_pkg::hblank_mode) && (mode != lcd_pkg::hblank_mode);
  assign lyc_hit      = (dot_count == '0) && coincidence;

  // Sources only count with the display running
  assign vblank_set = lcd_enable && enter_vblank;
  // Select bit 3 hblank, 4 vblank, 5 OAM, 6 LYC
  assign lcdc_set   = lcd_enable && ((enter_hblank && stat_select[0]) ||
                                     (enter_vblank && stat_select[1]) ||
                                     (enter_oam    && stat_select[2]) ||
                                     (lyc_hit      && stat_select[3]));

  ////////////////////////////////////////
  // Mode register and request flops
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      mode       <= lcd_pkg::hblank_mode;
      vblank_req <= 1'b0;
      lcdc_req   <= 1'b0;
    end else begin
      mode <= mode_next;
      // Set has priority over a same-edge ack
      if (vblank_set) begin
        vblank_req <= 1'b1;
      end else if (vblank_ack) begin
        vblank_req <= 1'b0;
      end
      if (lcdc_set) begin
        lcdc_req <= 1'b1;
      end else if (lcdc_ack) begin
        lcdc_req <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Host data byte and register value
  typedef logic [7:0] reg_byte_t;

  // Host address
  typedef logic [15:0] bus_addr_t;

  // Dot position within a line
  typedef logic [8:0] dot_count_t;

  // Line number within a frame (LY)
  typedef logic [7:0] line_count_t;

  // Writable upper part of STAT
  typedef logic [4:0] stat_bits_t;

  ////////////////////////////////////////
  // Display mode as seen in STAT bits 1-0
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    hblank_mode     = 2'd0,
    vblank_mode     = 2'd1,
    oam_search_mode = 2'd2,
    transfer_mode   = 2'd3
  } lcd_mode_e;

  // Register map
  localparam bus_addr_t lcdc_addr = 16'hFF40;
  localparam bus_addr_t stat_addr = 16'hFF41;
  localparam bus_addr_t ly_addr   = 16'hFF44;
  localparam bus_addr_t lyc_addr  = 16'hFF45;

  // Read value for anything outside the map
  localparam reg_byte_t unmapped_data = 8'hFF;

endpackage

`default_nettype wire

//--- verilog/lcd_video_timing.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_video_timing #(
  parameter int dot_divide      = 8,
  parameter int dots_per_line   = 456,
  parameter int lines_per_frame = 154,
  parameter int active_lines    = 144,
  parameter int oam_dots        = 80,
  parameter int transfer_dots   = 172,
  parameter int active_dots     = 160
) (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   lcd_enable,
  output lcd_pkg::dot_count_t   dot_count,
  output lcd_pkg::line_count_t  line_count,
  output logic                  hsync,
  output logic                  vsync
);

  // Divider needs at least one bit
  localparam int div_width = (dot_divide > 1) ? $clog2(dot_divide) : 1;

  typedef logic [div_width-1:0] div_count_t;

  // Wrap points and sync thresholds
  localparam lcd_pkg::dot_count_t  last_dot   = lcd_pkg::dot_count_t'(dots_per_line - 1);
  localparam lcd_pkg::line_count_t last_line  = lcd_pkg::line_count_t'(lines_per_frame - 1);
  localparam lcd_pkg::dot_count_t  hsync_dot  =
    lcd_pkg::dot_count_t'(oam_dots + transfer_dots + active_dots);
  localparam lcd_pkg::line_count_t vsync_line = lcd_pkg::line_count_t'(active_lines);

  div_count_t div_count;
  logic       dot_enable;

  ////////////////////////////////////////
  // Dot clock enable
  ////////////////////////////////////////

  assign dot_enable = (div_count == div_count_t'(dot_divide - 1));

  always_ff @(posedge clock) begin
    if (reset || dot_enable) begin
      div_count <= '0;
    end else begin
      div_count <= div_count + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Dot and line counters
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      dot_count  <= '0;
      line_count <= '0;
    end else if (dot_enable) begin
      if (!lcd_enable) begin
        // Display off parks the raster at the origin
        dot_count  <= '0;
        line_count <= '0;
      end else if (dot_count == last_dot) begin
        dot_count  <= '0;
        line_count <= (line_count == last_line) ? '0 : line_count + 1'b1;
      end else begin
        dot_count <= dot_count + 1'b1;
      end
    end
  end

  // Sync levels after the visible area
  assign hsync = (dot_count > hsync_dot);
  assign vsync = (line_count > vsync_line);

endmodule

`default_nettype wire
